/* hw/dma_fetch_pkg.sv */
package dma_fetch_pkg;

    // Engine geometry
    localparam int NUM_CHANNELS   = 3;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_BYTES     = 64;

    // Host side
    typedef logic [63:0] host_addr_t;
    typedef logic [13:0] line_count_t;

    // MMIO port
    typedef logic [15:0] mmio_addr_t;
    typedef logic [63:0] mmio_data_t;

    // Data path
    typedef logic [31:0] word_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_idx_t;

    // One bit per fetch channel
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

    // Descriptor loading order, one state per channel then armed
    typedef enum logic [1:0] {
        DESC_0,
        DESC_1,
        DESC_2,
        ARMED
    } host_state_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_VISIT,
        SEQ_WAIT
    } seq_state_e;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_WAIT,
        CH_LOAD,
        CH_EMIT
    } chan_state_e;

endpackage

/* hw/host_cfg.sv */
`timescale 1ns/1ps

module host_cfg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mmio_wr_en,
    input  dma_fetch_pkg::mmio_addr_t  mmio_wr_addr,
    input  dma_fetch_pkg::mmio_data_t  mmio_wr_data,
    output dma_fetch_pkg::mmio_data_t  mmio_rd_data,
    input  logic                       run_done,
    output dma_fetch_pkg::chan_mask_t  cfg_load,
    output dma_fetch_pkg::host_addr_t  cfg_addr,
    output dma_fetch_pkg::line_count_t cfg_lines,
    output logic                       cfg_enable,
    output logic                       run_go
);

    dma_fetch_pkg::host_state_e state;
    dma_fetch_pkg::host_state_e state_next;
    logic desc_wr;
    logic status_clr;
    logic status;
    logic run_go_next;

    // Descriptor writes have address bits 0 and 10 low
    assign desc_wr    = mmio_wr_en && !mmio_wr_addr[0] && !mmio_wr_addr[10];
    assign status_clr = mmio_wr_en && mmio_wr_addr[0];

    // Line count and enable ride in the address field
    assign cfg_addr   = mmio_wr_data;
    assign cfg_lines  = mmio_wr_addr[14:1];
    assign cfg_enable = mmio_wr_addr[15];

    always_comb begin
        state_next  = state;
        cfg_load    = '0;
        run_go_next = 1'b0;
        if (desc_wr) begin
            case (state)
                dma_fetch_pkg::DESC_0: begin
                    cfg_load[0] = 1'b1;
                    state_next  = dma_fetch_pkg::DESC_1;
                end
                dma_fetch_pkg::DESC_1: begin
                    cfg_load[1] = 1'b1;
                    state_next  = dma_fetch_pkg::DESC_2;
                end
                dma_fetch_pkg::DESC_2: begin
                    cfg_load[2] = 1'b1;
                    state_next  = dma_fetch_pkg::ARMED;
                end
                default: begin
                    // Fourth write kicks off the run
                    run_go_next = 1'b1;
                    state_next  = dma_fetch_pkg::DESC_0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dma_fetch_pkg::DESC_0;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_go <= 1'b0;
        end else begin
            run_go <= run_go_next;
        end
    end

    // Clear wins over a run ending in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= 1'b0;
        end else if (status_clr) begin
            status <= 1'b0;
        end else if (run_done) begin
            status <= 1'b1;
        end
    end

    assign mmio_rd_data = {{($bits(dma_fetch_pkg::mmio_data_t) - 1){1'b0}}, status};

endmodule

/* hw/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run_go,
    input  dma_fetch_pkg::chan_mask_t chan_enabled,
    input  dma_fetch_pkg::chan_mask_t chan_end,
    output dma_fetch_pkg::chan_mask_t chan_start,
    output logic                      run_done
);

    dma_fetch_pkg::seq_state_e state;
    dma_fetch_pkg::seq_state_e state_next;
    logic [$clog2(dma_fetch_pkg::NUM_CHANNELS)-1:0] idx;
    logic idx_inc;
    logic last_chan;
    logic done_next;

    assign last_chan = (int'(idx) == dma_fetch_pkg::NUM_CHANNELS - 1);

    always_comb begin
        state_next = state;
        idx_inc    = 1'b0;
        done_next  = 1'b0;
        chan_start = '0;
        case (state)
            dma_fetch_pkg::SEQ_IDLE: begin
                if (run_go) begin
                    state_next = dma_fetch_pkg::SEQ_VISIT;
                end
            end
            dma_fetch_pkg::SEQ_VISIT: begin
                if (chan_enabled[idx]) begin
                    chan_start[idx] = 1'b1;
                    state_next      = dma_fetch_pkg::SEQ_WAIT;
                end else if (last_chan) begin
                    done_next  = 1'b1;
                    state_next = dma_fetch_pkg::SEQ_IDLE;
                end else begin
                    // Skipped channel, move on next cycle
                    idx_inc = 1'b1;
                end
            end
            default: begin
                if (chan_end[idx]) begin
                    if (last_chan) begin
                        done_next  = 1'b1;
                        state_next = dma_fetch_pkg::SEQ_IDLE;
                    end else begin
                        idx_inc    = 1'b1;
                        state_next = dma_fetch_pkg::SEQ_VISIT;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= dma_fetch_pkg::SEQ_IDLE;
            idx      <= '0;
            run_done <= 1'b0;
        end else begin
            state    <= state_next;
            run_done <= done_next;
            if (state == dma_fetch_pkg::SEQ_IDLE) begin
                idx <= '0;
            end else if (idx_inc) begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

/* hw/fetch_channel.sv */
`timescale 1ns/1ps

module fetch_channel (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_load,
    input  dma_fetch_pkg::host_addr_t  cfg_addr,
    input  dma_fetch_pkg::line_count_t cfg_lines,
    input  logic                       cfg_enable,
    input  logic                       chan_start,
    input  logic                       dma_empty,
    output logic                       chan_enabled,
    output logic                       chan_end,
    output logic                       req_go,
    output dma_fetch_pkg::host_addr_t  req_addr,
    output dma_fetch_pkg::line_count_t req_size,
    output logic                       req_pop,
    output logic                       req_shift,
    output logic                       word_we
);

    dma_fetch_pkg::chan_state_e state;
    dma_fetch_pkg::chan_state_e state_next;
    dma_fetch_pkg::host_addr_t  base_addr;
    dma_fetch_pkg::line_count_t num_lines;
    dma_fetch_pkg::line_count_t lines_left;
    dma_fetch_pkg::word_idx_t   word_idx;
    logic enable;
    logic last_word;
    logic last_line;

    always_ff @(posedge clk) begin
        if (cfg_load) begin
            base_addr <= cfg_addr;
            num_lines <= cfg_lines;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else if (cfg_load) begin
            enable <= cfg_enable;
        end
    end

    assign last_word = (word_idx == dma_fetch_pkg::word_idx_t'(dma_fetch_pkg::WORDS_PER_LINE - 1));
    assign last_line = (lines_left == dma_fetch_pkg::line_count_t'(1));

    always_comb begin
        state_next = state;
        case (state)
            dma_fetch_pkg::CH_IDLE: begin
                if (chan_start) begin
                    state_next = dma_fetch_pkg::CH_WAIT;
                end
            end
            dma_fetch_pkg::CH_WAIT: begin
                // Zero-line descriptor ends right away
                if (lines_left == '0) begin
                    state_next = dma_fetch_pkg::CH_IDLE;
                end else if (!dma_empty) begin
                    state_next = dma_fetch_pkg::CH_LOAD;
                end
            end
            dma_fetch_pkg::CH_LOAD: begin
                state_next = dma_fetch_pkg::CH_EMIT;
            end
            default: begin
                if (last_word) begin
                    state_next = last_line ? dma_fetch_pkg::CH_IDLE : dma_fetch_pkg::CH_WAIT;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= dma_fetch_pkg::CH_IDLE;
            req_go     <= 1'b0;
            lines_left <= '0;
            word_idx   <= '0;
        end else begin
            state  <= state_next;
            req_go <= chan_start && (state == dma_fetch_pkg::CH_IDLE);
            if (chan_start && (state == dma_fetch_pkg::CH_IDLE)) begin
                lines_left <= num_lines;
            end else if (word_we && last_word) begin
                lines_left <= lines_left - 1'b1;
            end
            if (word_we) begin
                word_idx <= word_idx + 1'b1;
            end else begin
                word_idx <= '0;
            end
        end
    end

    assign chan_enabled = enable;
    assign req_addr     = base_addr;
    assign req_size     = num_lines;
    assign req_pop      = (state == dma_fetch_pkg::CH_LOAD);
    assign word_we      = (state == dma_fetch_pkg::CH_EMIT);
    assign req_shift    = word_we;
    assign chan_end     = (word_we && last_word && last_line)
                        || ((state == dma_fetch_pkg::CH_WAIT) && (lines_left == '0));

endmodule

/* hw/line_unpacker.sv */
`timescale 1ns/1ps

module line_unpacker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  dma_fetch_pkg::chan_mask_t  req_go,
    input  dma_fetch_pkg::host_addr_t  req_addr [dma_fetch_pkg::NUM_CHANNELS],
    input  dma_fetch_pkg::line_count_t req_size [dma_fetch_pkg::NUM_CHANNELS],
    input  dma_fetch_pkg::chan_mask_t  req_pop,
    input  dma_fetch_pkg::chan_mask_t  req_shift,
    input  dma_fetch_pkg::line_t       dma_rd_data,
    output logic                       dma_rd_go,
    output dma_fetch_pkg::host_addr_t  dma_rd_addr,
    output dma_fetch_pkg::line_count_t dma_rd_size,
    output logic                       dma_rd_en,
    output dma_fetch_pkg::word_t       word_data
);

    dma_fetch_pkg::word_t words [dma_fetch_pkg::WORDS_PER_LINE];

    // Only one channel is active at a time
    assign dma_rd_go = |req_go;
    assign dma_rd_en = |req_pop;

    always_comb begin
        dma_rd_addr = '0;
        dma_rd_size = '0;
        for (int i = 0; i < dma_fetch_pkg::NUM_CHANNELS; i++) begin
            if (req_go[i]) begin
                dma_rd_addr = req_addr[i];
                dma_rd_size = req_size[i];
            end
        end
    end

    // Word 0 sits at the low end of the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dma_fetch_pkg::WORDS_PER_LINE; i++) begin
                words[i] <= '0;
            end
        end else if (|req_pop) begin
            for (int i = 0; i < dma_fetch_pkg::WORDS_PER_LINE; i++) begin
                words[i] <= dma_rd_data[i*32 +: 32];
            end
        end else if (|req_shift) begin
            for (int i = 0; i < dma_fetch_pkg::WORDS_PER_LINE - 1; i++) begin
                words[i] <= words[i+1];
            end
        end
    end

    assign word_data = words[0];

endmodule

/* hw/dma_fetch_top.sv */
`timescale 1ns/1ps

module dma_fetch_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mmio_wr_en,
    input  dma_fetch_pkg::mmio_addr_t  mmio_wr_addr,
    input  dma_fetch_pkg::mmio_data_t  mmio_wr_data,
    output dma_fetch_pkg::mmio_data_t  mmio_rd_data,
    output logic                       dma_rd_go,
    output dma_fetch_pkg::host_addr_t  dma_rd_addr,
    output dma_fetch_pkg::line_count_t dma_rd_size,
    output logic                       dma_rd_en,
    input  logic                       dma_empty,
    input  dma_fetch_pkg::line_t       dma_rd_data,
    output dma_fetch_pkg::word_t       word_data,
    output dma_fetch_pkg::chan_mask_t  word_we,
    output logic                       fetch_done
);

    // Descriptor broadcast
    dma_fetch_pkg::chan_mask_t  cfg_load;
    dma_fetch_pkg::host_addr_t  cfg_addr;
    dma_fetch_pkg::line_count_t cfg_lines;
    logic                       cfg_enable;
    logic                       run_go;

    // Sequencer handshake
    dma_fetch_pkg::chan_mask_t chan_start;
    dma_fetch_pkg::chan_mask_t chan_end;
    dma_fetch_pkg::chan_mask_t chan_enabled;

    // Channel requests toward the unpacker
    dma_fetch_pkg::chan_mask_t  req_go;
    dma_fetch_pkg::chan_mask_t  req_pop;
    dma_fetch_pkg::chan_mask_t  req_shift;
    dma_fetch_pkg::host_addr_t  req_addr [dma_fetch_pkg::NUM_CHANNELS];
    dma_fetch_pkg::line_count_t req_size [dma_fetch_pkg::NUM_CHANNELS];

    host_cfg i_host_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .mmio_rd_data (mmio_rd_data),
        .run_done     (fetch_done),
        .cfg_load     (cfg_load),
        .cfg_addr     (cfg_addr),
        .cfg_lines    (cfg_lines),
        .cfg_enable   (cfg_enable),
        .run_go       (run_go)
    );

    fetch_sequencer i_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .run_go       (run_go),
        .chan_enabled (chan_enabled),
        .chan_end     (chan_end),
        .chan_start   (chan_start),
        .run_done     (fetch_done)
    );

    for (genvar gi = 0; gi < dma_fetch_pkg::NUM_CHANNELS; gi++) begin : g_chan
        fetch_channel i_chan (
            .clk          (clk),
            .rst_n        (rst_n),
            .cfg_load     (cfg_load[gi]),
            .cfg_addr     (cfg_addr),
            .cfg_lines    (cfg_lines),
            .cfg_enable   (cfg_enable),
            .chan_start   (chan_start[gi]),
            .dma_empty    (dma_empty),
            .chan_enabled (chan_enabled[gi]),
            .chan_end     (chan_end[gi]),
            .req_go       (req_go[gi]),
            .req_addr     (req_addr[gi]),
            .req_size     (req_size[gi]),
            .req_pop      (req_pop[gi]),
            .req_shift    (req_shift[gi]),
            .word_we      (word_we[gi])
        );
    end

    line_unpacker i_unpacker (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_go      (req_go),
        .req_addr    (req_addr),
        .req_size    (req_size),
        .req_pop     (req_pop),
        .req_shift   (req_shift),
        .dma_rd_data (dma_rd_data),
        .dma_rd_go   (dma_rd_go),
        .dma_rd_addr (dma_rd_addr),
        .dma_rd_size (dma_rd_size),
        .dma_rd_en   (dma_rd_en),
        .word_data   (word_data)
    );

endmodule

/* tests/dma_read_model.sv */
`timescale 1ns/1ps

module dma_read_model (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rd_go,
    input  dma_fetch_pkg::host_addr_t  rd_addr,
    input  dma_fetch_pkg::line_count_t rd_size,
    input  logic                       rd_en,
    input  logic                       stall,
    output logic                       empty,
    output dma_fetch_pkg::line_t       rd_data
);

    dma_fetch_pkg::host_addr_t  head_addr;
    dma_fetch_pkg::line_count_t lines_left;
    logic gap;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_addr  <= '0;
            lines_left <= '0;
        end else if (rd_go) begin
            head_addr  <= rd_addr;
            lines_left <= rd_size;
        end else if (rd_en && (lines_left != '0)) begin
            head_addr  <= head_addr + dma_fetch_pkg::LINE_BYTES;
            lines_left <= lines_left - 1'b1;
        end
    end

    // A visible head line stays visible until it is popped
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap <= 1'b0;
        end else if (empty || rd_en) begin
            gap <= stall;
        end
    end

    assign empty = gap || (lines_left == '0);

    // Each word holds the low bits of its own byte address
    always_comb begin
        for (int k = 0; k < dma_fetch_pkg::WORDS_PER_LINE; k++) begin
            rd_data[k*32 +: 32] = dma_fetch_pkg::word_t'(head_addr + 4 * k);
        end
    end

endmodule

/* tests/tb_dma_fetch.sv */
`timescale 1ns/1ps

module tb_dma_fetch;

    localparam int NUM_ROWS = 6;
    localparam int NCH      = dma_fetch_pkg::NUM_CHANNELS;
    localparam int WPL      = dma_fetch_pkg::WORDS_PER_LINE;
    localparam logic [31:0] RAND_SEED = 32'hff4a_b45b;
    // Rows that run with random FIFO empty gaps
    localparam logic [NUM_ROWS-1:0] GAP_ROWS = 6'b011100;

    logic                       clk;
    logic                       rst_n;
    logic                       mmio_wr_en;
    dma_fetch_pkg::mmio_addr_t  mmio_wr_addr;
    dma_fetch_pkg::mmio_data_t  mmio_wr_data;
    dma_fetch_pkg::mmio_data_t  mmio_rd_data;
    logic                       dma_rd_go;
    dma_fetch_pkg::host_addr_t  dma_rd_addr;
    dma_fetch_pkg::line_count_t dma_rd_size;
    logic                       dma_rd_en;
    logic                       dma_empty;
    dma_fetch_pkg::line_t       dma_rd_data;
    dma_fetch_pkg::word_t       word_data;
    dma_fetch_pkg::chan_mask_t  word_we;
    logic                       fetch_done;
    logic                       stall;
    logic                       stall_on;
    logic                       table_ready;

    // Stimulus table, one descriptor per row and channel
    dma_fetch_pkg::host_addr_t  row_addr  [NUM_ROWS][NCH];
    dma_fetch_pkg::line_count_t row_lines [NUM_ROWS][NCH];
    logic                       row_en    [NUM_ROWS][NCH];
    int                         row_words [NUM_ROWS][NCH];

    // Expected traffic of the row in progress
    int                         exp_chan [$];
    dma_fetch_pkg::word_t       exp_word [$];
    dma_fetch_pkg::host_addr_t  exp_go_addr [$];
    dma_fetch_pkg::line_count_t exp_go_size [$];

    int chan_words [NCH];
    int err_count;
    int words_checked;
    int done_count;
    int wd_limit;
    int mon_ch;
    int mon_exp_ch;
    dma_fetch_pkg::word_t       mon_exp_word;
    dma_fetch_pkg::host_addr_t  mon_addr;
    dma_fetch_pkg::line_count_t mon_size;
    int unsigned seed_ret;

    dma_fetch_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .mmio_rd_data (mmio_rd_data),
        .dma_rd_go    (dma_rd_go),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_size  (dma_rd_size),
        .dma_rd_en    (dma_rd_en),
        .dma_empty    (dma_empty),
        .dma_rd_data  (dma_rd_data),
        .word_data    (word_data),
        .word_we      (word_we),
        .fetch_done   (fetch_done)
    );

    dma_read_model i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_go   (dma_rd_go),
        .rd_addr (dma_rd_addr),
        .rd_size (dma_rd_size),
        .rd_en   (dma_rd_en),
        .stall   (stall),
        .empty   (dma_empty),
        .rd_data (dma_rd_data)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        err_count++;
        $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    endtask

    function automatic int mask_to_index(input dma_fetch_pkg::chan_mask_t mask);
        int idx;
        idx = -1;
        for (int i = 0; i < NCH; i++) begin
            if (mask[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic set_desc(input int r, input int ch, input dma_fetch_pkg::host_addr_t addr,
                            input int lines, input logic en, input int words);
        row_addr[r][ch]  = addr;
        row_lines[r][ch] = dma_fetch_pkg::line_count_t'(lines);
        row_en[r][ch]    = en;
        row_words[r][ch] = words;
    endtask

    task automatic load_table();
        // row, channel, base address, lines, enable, expected words
        set_desc(0, 0, 64'h0000_0000_1000_0000, 2, 1'b1, 32);
        set_desc(0, 1, 64'h0000_0000_2000_0000, 3, 1'b0, 0);
        set_desc(0, 2, 64'h0000_0000_3000_0000, 1, 1'b0, 0);
        set_desc(1, 0, 64'h0000_0001_0000_0040, 1, 1'b1, 16);
        set_desc(1, 1, 64'h0000_0000_2000_0100, 2, 1'b1, 32);
        set_desc(1, 2, 64'h0000_00ff_ffff_ff80, 3, 1'b1, 48);
        set_desc(2, 0, 64'h0000_0000_0000_4000, 1, 1'b0, 0);
        set_desc(2, 1, 64'h0000_0000_0abc_0000, 4, 1'b1, 64);
        set_desc(2, 2, 64'h0000_0000_0000_8000, 1, 1'b0, 0);
        set_desc(3, 0, 64'h0000_0000_0000_c000, 2, 1'b0, 0);
        set_desc(3, 1, 64'h0000_0000_0001_0000, 2, 1'b0, 0);
        set_desc(3, 2, 64'h0000_1234_5678_0000, 2, 1'b1, 32);
        set_desc(4, 0, 64'h0000_0000_c000_0000, 3, 1'b1, 48);
        set_desc(4, 1, 64'h0000_0000_c000_1000, 1, 1'b1, 16);
        set_desc(4, 2, 64'h0000_0000_c000_2000, 2, 1'b1, 32);
        set_desc(5, 0, 64'h0000_0000_5000_0000, 1, 1'b0, 0);
        set_desc(5, 1, 64'h0000_0000_6000_0000, 1, 1'b0, 0);
        set_desc(5, 2, 64'h0000_0000_7000_0000, 1, 1'b0, 0);
    endtask

    task automatic mmio_write(input dma_fetch_pkg::mmio_addr_t addr,
                              input dma_fetch_pkg::mmio_data_t data);
        @(posedge clk);
        mmio_wr_en   <= 1'b1;
        mmio_wr_addr <= addr;
        mmio_wr_data <= data;
        @(posedge clk);
        mmio_wr_en   <= 1'b0;
    endtask

    task automatic drive_gaps();
        forever begin
            @(posedge clk);
            stall <= stall_on && (($urandom % 3) == 0);
        end
    endtask

    task automatic run_row(input int r);
        dma_fetch_pkg::mmio_addr_t desc;
        int start_done;
        for (int ch = 0; ch < NCH; ch++) begin
            chan_words[ch] = 0;
            if (row_en[r][ch]) begin
                exp_go_addr.push_back(row_addr[r][ch]);
                exp_go_size.push_back(row_lines[r][ch]);
                for (int j = 0; j < int'(row_lines[r][ch]); j++) begin
                    for (int k = 0; k < WPL; k++) begin
                        exp_chan.push_back(ch);
                        exp_word.push_back(dma_fetch_pkg::word_t'(row_addr[r][ch]
                            + dma_fetch_pkg::LINE_BYTES * j + 4 * k));
                    end
                end
            end
        end
        start_done = done_count;
        stall_on   = GAP_ROWS[r];
        // Line count in bits 14 to 1, enable in bit 15
        for (int ch = 0; ch < NCH; ch++) begin
            desc = {row_en[r][ch], row_lines[r][ch], 1'b0};
            mmio_write(desc, row_addr[r][ch]);
        end
        mmio_write('0, '0);
        do begin
            @(negedge clk);
        end while (!fetch_done);
        @(negedge clk);
        stall_on = 1'b0;
        if (fetch_done !== 1'b0) begin
            report_mismatch($sformatf("row%0d fetch_done pulse", r), 0, fetch_done);
        end
        if (mmio_rd_data !== 64'd1) begin
            report_mismatch($sformatf("row%0d status after run", r), 1, mmio_rd_data);
        end
        if (exp_word.size() != 0 || exp_go_addr.size() != 0) begin
            err_count++;
            $display("ERROR: row%0d ended with %0d words and %0d read starts missing",
                     r, exp_word.size(), exp_go_addr.size());
        end
        for (int ch = 0; ch < NCH; ch++) begin
            if (chan_words[ch] != row_words[r][ch]) begin
                report_mismatch($sformatf("row%0d ch%0d word count", r, ch),
                                row_words[r][ch], chan_words[ch]);
            end
        end
        exp_chan.delete();
        exp_word.delete();
        exp_go_addr.delete();
        exp_go_size.delete();
        mmio_write(16'h0001, '0);
        // Pulses counted from the row start up to the clear write
        if (done_count - start_done != 1) begin
            report_mismatch($sformatf("row%0d done pulses", r), 1, done_count - start_done);
        end
        @(negedge clk);
        if (mmio_rd_data !== 64'd0) begin
            report_mismatch($sformatf("row%0d status after clear", r), 0, mmio_rd_data);
        end
    endtask

    // Output monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (dma_rd_en && dma_empty) begin
                err_count++;
                $display("ERROR: line popped while the read FIFO was empty at %0t", $time);
            end
            if (dma_rd_go) begin
                if (exp_go_addr.size() == 0) begin
                    err_count++;
                    $display("ERROR: unexpected dma_rd_go with address %0h", dma_rd_addr);
                end else begin
                    mon_addr = exp_go_addr.pop_front();
                    mon_size = exp_go_size.pop_front();
                    if (dma_rd_addr !== mon_addr) begin
                        report_mismatch("dma_rd_addr", mon_addr, dma_rd_addr);
                    end
                    if (dma_rd_size !== mon_size) begin
                        report_mismatch("dma_rd_size", mon_size, dma_rd_size);
                    end
                end
            end
            if (word_we != '0) begin
                mon_ch = mask_to_index(word_we);
                if ((word_we & (word_we - 1'b1)) != '0) begin
                    err_count++;
                    $display("ERROR: word_we %b has more than one bit set", word_we);
                end else if (exp_word.size() == 0) begin
                    err_count++;
                    $display("ERROR: unexpected word %0h on channel %0d", word_data, mon_ch);
                end else begin
                    mon_exp_ch   = exp_chan.pop_front();
                    mon_exp_word = exp_word.pop_front();
                    if (mon_ch != mon_exp_ch) begin
                        report_mismatch($sformatf("word%0d channel", words_checked),
                                        mon_exp_ch, mon_ch);
                    end
                    if (word_data !== mon_exp_word) begin
                        report_mismatch($sformatf("word%0d data", words_checked),
                                        mon_exp_word, word_data);
                    end
                    chan_words[mon_ch]++;
                    words_checked++;
                end
            end
            if (fetch_done) begin
                done_count++;
            end
        end
    end

    initial begin
        wait (table_ready);
        wd_limit = 100 + 100 * NUM_ROWS;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int ch = 0; ch < NCH; ch++) begin
                wd_limit += 40 * int'(row_lines[r][ch]);
            end
        end
        repeat (wd_limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", wd_limit);
        $display("Summary: %0d errors, %0d words checked", err_count, words_checked);
        $display("test failed");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        mmio_wr_en    = 1'b0;
        mmio_wr_addr  = '0;
        mmio_wr_data  = '0;
        stall         = 1'b0;
        stall_on      = 1'b0;
        err_count     = 0;
        words_checked = 0;
        done_count    = 0;
        table_ready   = 1'b0;
        seed_ret      = $urandom(RAND_SEED);
        load_table();
        table_ready = 1'b1;
        fork
            drive_gaps();
        join_none
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (word_we !== '0) begin
            report_mismatch("reset word_we", 0, word_we);
        end
        if (dma_rd_go !== 1'b0 || dma_rd_en !== 1'b0) begin
            report_mismatch("reset dma_rd_go/dma_rd_en", 0, {dma_rd_go, dma_rd_en});
        end
        if (fetch_done !== 1'b0) begin
            report_mismatch("reset fetch_done", 0, fetch_done);
        end
        if (mmio_rd_data !== 64'd0) begin
            report_mismatch("reset status", 0, mmio_rd_data);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Summary: %0d errors, %0d words checked", err_count, words_checked);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/dma_fetch_pkg.sv
hw/host_cfg.sv
hw/fetch_sequencer.sv
hw/fetch_channel.sv
hw/line_unpacker.sv
hw/dma_fetch_top.sv
tests/dma_read_model.sv
tests/tb_dma_fetch.sv
